// ==== test/cq_testdata.txt ====
// entry(128b) err_inject flush_req expected_kind(0 flush 1 fence 2 illegal 3 mem fault)
// fence_write_addr fence_write_data
000000000048d0000000300005001401 0 002a0001234000300005000000000000 0 0 0
00000000000000000000700000002081 0 00140000000000700000000000000000 0 0 0
00000000000000000000420200000003 0 0000000000000000000000c00010a00000 0 0 0
0000000000002000cafef00d00000c02 0 0 1 00002000 cafef00d
00000000000000000000000000001081 0 0 2 0 0
00000000000000000000090200077083 0 00000000000000000000400002700077 0 0 0
00000000000000000000000000000001 1 0 3 0 0
0000000000000000000000000000007f 0 0 2 0 0
00000000000000000000000011000001 0 00200000000000000011000000000000 0 0 0
00000000000020201234567800000c02 0 0 1 00002020 12345678

// ==== tb.f ====
verilog/cq_pkg.sv
verilog/cq_inval_decode.sv
verilog/cq_fence_decode.sv
verilog/cq_mem_port.sv
verilog/cq_control.sv
verilog/cq_handler.sv
test/tb_cq_handler.sv

// ==== Bender.yml ====
package:
  name: cq_handler

sources:
  - verilog/cq_pkg.sv
  - verilog/cq_inval_decode.sv
  - verilog/cq_fence_decode.sv
  - verilog/cq_mem_port.sv
  - verilog/cq_control.sv
  - verilog/cq_handler.sv
  - target: test
    files:
      - test/tb_cq_handler.sv

// ==== test/tb_cq_handler.sv ====
// Handler testbench; needs test/cq_testdata.txt with 6 words per entry, queue of 8 entries at 0x1000
`timescale 1ns/1ns

module tb_cq_handler import cq_pkg::*; ();

    localparam int N     = 10;                 // Entries in the data file
    localparam int Q     = 8;                  // Queue entries for cq_size_i = 2
    localparam int LIMIT = 10 + 40 * N + 60;   // Reset, per-entry budget, enable/disable tail

    logic clk_i, rst_ni, cq_en_i, cq_ie_i, wsi_en_i, err_clr_i;
    logic [19:0] cq_base_ppn_i;
    logic [4:0]  cq_size_i;
    logic [31:0] cq_tail_i, cq_head_o;
    logic cq_on_o, busy_o, cq_mf_o, cmd_ill_o, fence_w_ip_o, cq_ip_o, flush_valid_o;
    flush_req_t flush_o;
    logic mem_req_o, mem_ack_i;
    mem_cmd_t mem_cmd_o;
    mem_rsp_t mem_rsp_i;

    logic [127:0] td [0:N*6-1];   // entry, err, flush, kind, fence addr, fence data
    integer seed, delay, cycles, fetch_cnt, flush_cnt, exp_flush, nwr, k;
    logic [31:0] wr_addr_q[$], wr_data_q[$];

    cq_handler #(.PPN_W(20), .ADDR_W(32)) cq_handler_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #10;   // Drive and sample point
    endtask

    // Hang guard
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: the handler stopped making progress");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    always @(posedge clk_i) if (flush_valid_o) flush_cnt <= flush_cnt + 1;

    // Memory model serving the k-th fetch with data line k after a random ack latency
    initial begin
        forever begin
            next_cycle();
            if (mem_ack_i && !mem_req_o) begin
                mem_ack_i = 1'b0;                 // Phase 4
            end else if (!mem_ack_i && mem_req_o) begin
                if (delay > 0) begin
                    delay = delay - 1;
                end else begin
                    mem_rsp_i = '0;
                    if (mem_cmd_o.we) begin
                        wr_addr_q.push_back(mem_cmd_o.addr[31:0]);
                        wr_data_q.push_back(mem_cmd_o.wdata);
                    end else begin
                        if (fetch_cnt >= N) begin
                            $display("Fetch beyond the end of the test data");
                            $display("=== FAIL ===");
                            $fatal(1);
                        end
                        check_value(mem_cmd_o.addr, 32'h1000 + ((fetch_cnt % Q) * 16),
                                    "fetch address");
                        mem_rsp_i.rdata = td[fetch_cnt*6];
                        mem_rsp_i.err   = td[fetch_cnt*6+1][0];   // Injected fault
                        fetch_cnt = fetch_cnt + 1;
                    end
                    mem_ack_i = 1'b1;
                    delay = {$random(seed)} % 4;
                end
            end
        end
    end

    initial begin
        seed = 32'h34d87cf9;
        rst_ni = 1'b0;
        cq_en_i = 1'b0;
        cq_ie_i = 1'b1;
        wsi_en_i = 1'b1;
        err_clr_i = 1'b0;
        cq_base_ppn_i = 20'h00001;
        cq_size_i = 5'd2;
        cq_tail_i = '0;
        mem_ack_i = 1'b0;
        mem_rsp_i = '0;
        cycles = 0;
        fetch_cnt = 0;
        flush_cnt = 0;
        exp_flush = 0;
        nwr = 0;
        delay = 0;
        $readmemh("test/cq_testdata.txt", td);
        repeat (10) @(posedge clk_i);
        #10 rst_ni = 1'b1;
        next_cycle();
        cq_en_i = 1'b1;
        #1 check_value(busy_o, 1, "busy on enable");
        next_cycle();
        check_value(busy_o, 0, "busy after enable");
        check_value(cq_on_o, 1, "cq_on after enable");
        check_value(cq_head_o, 0, "head after enable");

        for (k = 0; k < N; k++) begin
            cq_tail_i = (k + 1) % Q;               // One new entry at a time
            case (td[k*6+3])
                0: begin
                    while (!flush_valid_o) next_cycle();
                    check_value(flush_o, td[k*6+2], "flush request");
                    exp_flush++;
                    next_cycle();                  // Past the one-cycle pulse
                end
                1: begin
                    while (wr_addr_q.size() == nwr) next_cycle();
                    check_value(wr_addr_q[nwr], td[k*6+4], "fence write address");
                    check_value(wr_data_q[nwr], td[k*6+5], "fence write data");
                    nwr++;
                    check_value(fence_w_ip_o, 1, "fence_w_ip");
                    check_value(cq_ip_o, 1, "cq_ip with fence_w_ip");
                    err_clr_i = 1'b1;
                    next_cycle();
                    err_clr_i = 1'b0;
                end
                default: begin
                    while (!(cmd_ill_o || cq_mf_o)) next_cycle();
                    check_value(cmd_ill_o, td[k*6+3] == 2, "cmd_ill");
                    check_value(cq_mf_o, td[k*6+3] == 3, "cq_mf");
                    check_value(cq_ip_o, cq_ie_i, "cq_ip on error");
                    cq_tail_i = (k + 2) % Q;       // Pending work waits for err_clr
                    cq_ie_i = 1'b0;                // Pending bit masked
                    repeat (5) next_cycle();
                    check_value(cq_ip_o, 0, "cq_ip masked by cq_ie");
                    check_value(fetch_cnt, k + 1, "no fetch while stopped");
                    check_value(flush_cnt, exp_flush, "flush count");
                    cq_ie_i = 1'b1;
                    err_clr_i = 1'b1;
                    cq_tail_i = (k + 1) % Q;
                    next_cycle();
                    err_clr_i = 1'b0;
                    check_value(cmd_ill_o | cq_mf_o, 0, "error bits after clear");
                end
            endcase
            check_value(cq_head_o, (k + 1) % Q, "head index");
        end

        repeat (3) next_cycle();
        check_value(flush_cnt, exp_flush, "total flush count");
        check_value(wr_addr_q.size(), nwr, "fence write count");
        check_value(cq_head_o, N % Q, "final head with wrap");
        cq_en_i = 1'b0;
        #1 check_value(busy_o, 1, "busy on disable");
        next_cycle();
        check_value(busy_o, 0, "busy after disable");
        check_value(cq_on_o, 0, "cq_on after disable");
        cq_tail_i = 5;
        repeat (10) next_cycle();
        check_value(fetch_cnt, N, "no fetch while disabled");
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog/cq_handler.sv ====
// Command queue handler top; ADDR_W must be at least PPN_W+12, one memory transfer in flight
`timescale 1ns/1ns

module cq_handler import cq_pkg::*; #(
    parameter int unsigned PPN_W  = 44,   // Queue base PPN width
    parameter int unsigned ADDR_W = 56    // Physical address width
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [PPN_W-1:0]  cq_base_ppn_i,
    input  logic [4:0]        cq_size_i,      // log2(entries) - 1
    input  logic [31:0]       cq_tail_i,
    input  logic              cq_en_i,
    input  logic              cq_ie_i,
    input  logic              wsi_en_i,
    input  logic              err_clr_i,      // Pulse clears all sticky error bits
    output logic [31:0]       cq_head_o,
    output logic              cq_on_o,
    output logic              busy_o,
    output logic              cq_mf_o,
    output logic              cmd_ill_o,
    output logic              fence_w_ip_o,
    output logic              cq_ip_o,
    output logic              flush_valid_o,
    output flush_req_t        flush_o,
    output logic              mem_req_o,
    output mem_cmd_t          mem_cmd_o,
    input  logic              mem_ack_i,
    input  mem_rsp_t          mem_rsp_i
);

    logic       mem_start, mem_done;
    mem_cmd_t   mem_cmd;
    mem_rsp_t   mem_rsp;
    cq_entry_t  entry;                      // Registered command, shared by both decoders

    logic       inval_claim, inval_ill;
    flush_req_t inval_flush;
    logic       fence_claim, fence_ill, fence_wr, fence_wsi;
    mem_cmd_t   fence_cmd;

    cq_control #(.PPN_W(PPN_W), .ADDR_W(ADDR_W)) cq_control_inst (
        .clk_i, .rst_ni, .cq_base_ppn_i, .cq_size_i, .cq_tail_i, .cq_en_i, .cq_ie_i, .err_clr_i,
        .cq_head_o, .cq_on_o, .busy_o, .cq_mf_o, .cmd_ill_o, .fence_w_ip_o, .cq_ip_o,
        .flush_valid_o, .flush_o,
        .mem_start_o(mem_start), .mem_cmd_o(mem_cmd), .mem_done_i(mem_done), .mem_rsp_i(mem_rsp),
        .entry_o(entry),
        .inval_claim_i(inval_claim), .inval_ill_i(inval_ill), .flush_i(inval_flush),
        .fence_claim_i(fence_claim), .fence_ill_i(fence_ill), .fence_wr_i(fence_wr),
        .fence_cmd_i(fence_cmd), .fence_wsi_i(fence_wsi)
    );

    cq_inval_decode cq_inval_decode_inst (
        .entry_i(entry), .claim_o(inval_claim), .illegal_o(inval_ill), .flush_o(inval_flush)
    );

    cq_fence_decode #(.ADDR_W(ADDR_W)) cq_fence_decode_inst (
        .entry_i(entry), .wsi_en_i, .claim_o(fence_claim), .illegal_o(fence_ill),
        .wr_o(fence_wr), .wr_cmd_o(fence_cmd), .wsi_set_o(fence_wsi)
    );

    cq_mem_port cq_mem_port_inst (
        .clk_i, .rst_ni, .start_i(mem_start), .cmd_i(mem_cmd), .done_o(mem_done), .rsp_o(mem_rsp),
        .mem_req_o, .mem_cmd_o, .mem_ack_i, .mem_rsp_i
    );

endmodule

// ==== verilog/cq_control.sv ====
// Queue FSM and sticky status; cq_en_i changes take effect only while idle; errors need err_clr_i
`timescale 1ns/1ns

module cq_control import cq_pkg::*; #(
    parameter int unsigned PPN_W  = 44,
    parameter int unsigned ADDR_W = 56
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [PPN_W-1:0] cq_base_ppn_i,
    input  logic [4:0]       cq_size_i,
    input  logic [31:0]      cq_tail_i,
    input  logic             cq_en_i,
    input  logic             cq_ie_i,
    input  logic             err_clr_i,
    output logic [31:0]      cq_head_o,
    output logic             cq_on_o,
    output logic             busy_o,
    output logic             cq_mf_o,
    output logic             cmd_ill_o,
    output logic             fence_w_ip_o,
    output logic             cq_ip_o,
    output logic             flush_valid_o,
    output flush_req_t       flush_o,
    output logic             mem_start_o,
    output mem_cmd_t         mem_cmd_o,
    input  logic             mem_done_i,
    input  mem_rsp_t         mem_rsp_i,
    output cq_entry_t        entry_o,
    input  logic             inval_claim_i,
    input  logic             inval_ill_i,
    input  flush_req_t       flush_i,
    input  logic             fence_claim_i,
    input  logic             fence_ill_i,
    input  logic             fence_wr_i,
    input  mem_cmd_t         fence_cmd_i,
    input  logic             fence_wsi_i
);

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, WRITE, ERROR} ctrl_state_e;
    ctrl_state_e state_q, state_n;

    logic              en_q;                    // Enable as seen by the handler
    logic [31:0]       head_q;
    logic              mf_q, ill_q, wip_q;      // Sticky cq_mf, cmd_ill, fence_w_ip
    cq_entry_t         entry_q;
    logic [31:0]       idx_mask;
    logic [31:0]       head_next;
    logic [31:0]       tail_m;
    logic [ADDR_W-1:0] fetch_addr;
    mem_cmd_t          fetch_cmd;
    logic              dec_ill;

    assign idx_mask  = ~(32'hffff_ffff << (cq_size_i + 1));  // 2^(size+1) entries
    assign head_next = (head_q + 32'd1) & idx_mask;           // Wraps at queue size
    assign tail_m    = cq_tail_i & idx_mask;

    // Entry address = base + head * 16
    assign fetch_addr = ADDR_W'({cq_base_ppn_i, 12'h000})
                      + (ADDR_W'(head_q) << CQ_ENTRY_BYTES_LOG2);
    assign fetch_cmd  = '{we: 1'b0, addr: MEM_ADDR_W'(fetch_addr), wdata: '0};

    // No claim from either decoder means a reserved opcode
    assign dec_ill = !(inval_claim_i || fence_claim_i)
                   || (inval_claim_i && inval_ill_i)
                   || (fence_claim_i && fence_ill_i);

    assign busy_o        = (cq_en_i != en_q);   // One cycle per enable change when idle
    assign cq_on_o       = en_q;
    assign cq_head_o     = head_q;
    assign cq_mf_o       = mf_q;
    assign cmd_ill_o     = ill_q;
    assign fence_w_ip_o  = wip_q;
    assign cq_ip_o       = (mf_q || ill_q || wip_q) && cq_ie_i;
    assign entry_o       = entry_q;
    assign flush_valid_o = (state_q == DECODE) && inval_claim_i && !inval_ill_i;
    assign flush_o       = flush_i;

    always_comb begin
        state_n     = state_q;
        mem_start_o = 1'b0;
        mem_cmd_o   = fetch_cmd;
        case (state_q)
            IDLE: begin
                // Enable cycle itself never fetches since en_q is still low
                if (cq_en_i && en_q && (tail_m != head_q)) begin
                    mem_start_o = 1'b1;
                    state_n     = FETCH;
                end
            end
            FETCH:  if (mem_done_i) state_n = mem_rsp_i.err ? ERROR : DECODE;
            DECODE: begin
                if (dec_ill) begin
                    state_n = ERROR;
                end else if (fence_claim_i && fence_wr_i) begin
                    mem_start_o = 1'b1;          // IOFENCE.C data write
                    mem_cmd_o   = fence_cmd_i;
                    state_n     = WRITE;
                end else begin
                    state_n = IDLE;
                end
            end
            WRITE:  if (mem_done_i) state_n = mem_rsp_i.err ? ERROR : IDLE;
            ERROR:  if (err_clr_i) state_n = IDLE;   // Stopped until software clears
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            en_q    <= 1'b0;
            head_q  <= '0;
            mf_q    <= 1'b0;
            ill_q   <= 1'b0;
            wip_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            if (err_clr_i) begin
                mf_q  <= 1'b0;
                ill_q <= 1'b0;
                wip_q <= 1'b0;
            end
            case (state_q)
                IDLE: begin
                    en_q <= cq_en_i;
                    if (cq_en_i && !en_q) begin   // Fresh enable restarts the queue
                        head_q <= '0;
                        mf_q   <= 1'b0;
                        ill_q  <= 1'b0;
                        wip_q  <= 1'b0;
                    end
                end
                FETCH: begin
                    if (mem_done_i) begin
                        head_q <= head_next;      // Advances past faulting entries too
                        if (mem_rsp_i.err) mf_q <= 1'b1;
                    end
                end
                DECODE: begin
                    if (dec_ill) ill_q <= 1'b1;
                    else if (fence_claim_i && fence_wsi_i) wip_q <= 1'b1;
                end
                WRITE: if (mem_done_i && mem_rsp_i.err) mf_q <= 1'b1;
                default: ;
            endcase
        end
    end

    // Entry payload register
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH && mem_done_i) entry_q <= mem_rsp_i.rdata;
    end

    // Single-cycle flush, never for an entry that the fence decoder also claims
    a_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_valid_o |-> !fence_claim_i ##1 !flush_valid_o);

    // Exactly one cache kind is targeted per flush
    a_flush_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_valid_o |-> $onehot({flush_o.vma, flush_o.gvma, flush_o.pdtc}));

endmodule

// ==== verilog/cq_mem_port.sv ====
// Four-phase req/ack master; one transfer at a time, a start during release waits for ack low
`timescale 1ns/1ns

module cq_mem_port import cq_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     start_i,
    input  mem_cmd_t cmd_i,
    output logic     done_o,
    output mem_rsp_t rsp_o,
    output logic     mem_req_o,
    output mem_cmd_t mem_cmd_o,
    input  logic     mem_ack_i,
    input  mem_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {IDLE, REQ, RELEASE} port_state_e;
    port_state_e state_q;

    mem_cmd_t cmd_q;
    mem_rsp_t rsp_q;
    logic     done_q;
    logic     pend_q;   // Start seen while the previous ack is still high
    logic     go;

    assign go = start_i || pend_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
            pend_q  <= 1'b0;
        end else begin
            done_q <= (state_q == REQ) && mem_ack_i;
            case (state_q)
                IDLE:    if (go) state_q <= REQ;
                REQ:     if (mem_ack_i) state_q <= RELEASE;
                RELEASE: if (!mem_ack_i) state_q <= go ? REQ : IDLE;   // Ack low ends phase 4
                default: state_q <= IDLE;
            endcase
            pend_q <= go && (state_q == RELEASE) && mem_ack_i;
        end
    end

    // Command and response payload
    always_ff @(posedge clk_i) begin
        if (start_i) cmd_q <= cmd_i;
        if (state_q == REQ && mem_ack_i) rsp_q <= mem_rsp_i;   // Sampled with the ack
    end

    assign mem_req_o = (state_q == REQ);
    assign mem_cmd_o = cmd_q;
    assign done_o    = done_q;
    assign rsp_o     = rsp_q;

    a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_cmd_o));

    // A new request only follows an ack already seen low
    a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_req_o) |-> !$past(mem_ack_i));

endmodule

// ==== verilog/cq_fence_decode.sv ====
// IOFENCE.C decode; PR and PW are accepted but have no effect, write address truncated to ADDR_W
`timescale 1ns/1ns

module cq_fence_decode import cq_pkg::*; #(
    parameter int unsigned ADDR_W = 56
) (
    input  cq_entry_t entry_i,
    input  logic      wsi_en_i,
    output logic      claim_o,
    output logic      illegal_o,
    output logic      wr_o,
    output mem_cmd_t  wr_cmd_o,
    output logic      wsi_set_o
);

    cq_iofence_t       fen;
    logic              ok;              // Claimed and legal
    logic [ADDR_W-1:0] wr_addr;

    assign fen = cq_iofence_t'(entry_i);

    assign claim_o   = (entry_i.opcode == IOFENCE);
    assign illegal_o = claim_o && ((|fen.rsvd_1) || (|fen.rsvd_2)
                                   || (iofence_func_e'(fen.func3) != FENCE_C));
    assign ok        = claim_o && !illegal_o;

    // 4-byte aligned target, ADDR[63:2] * 4
    assign wr_addr   = ADDR_W'({fen.addr, 2'b00});

    assign wr_o      = ok && fen.av;
    assign wr_cmd_o  = '{we: 1'b1, addr: MEM_ADDR_W'(wr_addr), wdata: fen.data};
    assign wsi_set_o = ok && fen.wsi && wsi_en_i;   // Only with wired interrupts

endmodule

// ==== verilog/cq_inval_decode.sv ====
// IOTINVAL and IODIR decode; flush fields are zero whenever the command is illegal or unclaimed
`timescale 1ns/1ns

module cq_inval_decode import cq_pkg::*; (
    input  cq_entry_t  entry_i,
    output logic       claim_o,
    output logic       illegal_o,
    output flush_req_t flush_o
);

    cq_iotinval_t iot;
    cq_iodir_t    dir;
    logic         is_iot, is_dir;
    logic         iot_ill, dir_ill;

    assign iot    = cq_iotinval_t'(entry_i);
    assign dir    = cq_iodir_t'(entry_i);
    assign is_iot = (entry_i.opcode == IOTINVAL);
    assign is_dir = (entry_i.opcode == IODIR);

    assign claim_o   = is_iot || is_dir;
    assign illegal_o = (is_iot && iot_ill) || (is_dir && dir_ill);

    always_comb begin
        iot_ill = (|iot.rsvd_1) || (|iot.rsvd_2) || (|iot.rsvd_3)
               || (|iot.rsvd_4) || (|iot.rsvd_5);
        case (iotinval_func_e'(iot.func3))
            VMA:     ;
            GVMA:    if (iot.pscv) iot_ill = 1'b1;   // PSCV not allowed with GVMA
            default: iot_ill = 1'b1;
        endcase

        dir_ill = (|dir.rsvd_1) || (|dir.rsvd_2) || (|dir.rsvd_3) || (|dir.rsvd_4);
        case (iodir_func_e'(dir.func3))
            INVAL_DDT: if (|dir.pid) dir_ill = 1'b1;   // PID is reserved here
            INVAL_PDT: if (!dir.dv) dir_ill = 1'b1;    // Needs a device
            default:   dir_ill = 1'b1;
        endcase
    end

    always_comb begin
        flush_o = '0;
        if (is_iot && !iot_ill) begin
            flush_o.vma   = (iot.func3 == VMA);
            flush_o.gvma  = (iot.func3 == GVMA);
            flush_o.pscv  = (iot.func3 == VMA) && iot.pscv;
            flush_o.av    = iot.av;
            flush_o.gv    = iot.gv;
            flush_o.vpn   = iot.addr[GPPN_W-1:0];   // Low bits of ADDR[63:12]
            flush_o.gscid = iot.gscid;
            flush_o.pscid = iot.pscid;
        end
        if (is_dir && !dir_ill) begin
            flush_o.ddtc = (dir.func3 == INVAL_DDT);
            flush_o.pdtc = 1'b1;                         // DDT flush also drops PDT entries
            flush_o.pv   = (dir.func3 == INVAL_PDT);
            flush_o.pid  = (dir.func3 == INVAL_PDT) ? dir.pid : '0;
            flush_o.dv   = dir.dv;
            flush_o.did  = dir.did;
        end
    end

endmodule

// ==== verilog/cq_pkg.sv ====
// Shared types for the command queue handler; ATS opcodes are not defined and count as reserved
package cq_pkg;

    localparam int unsigned CQ_ENTRY_BYTES_LOG2 = 4;   // 16-byte queue entries
    localparam int unsigned MEM_ADDR_W          = 56;  // Address field width on the memory port
    localparam int unsigned GPPN_W              = 29;  // Sv39x4 guest PPN width kept in flushes

    // Command opcodes, any other value is reserved
    typedef enum logic [6:0] {
        IOTINVAL = 7'd1,
        IOFENCE  = 7'd2,
        IODIR    = 7'd3
    } cq_opcode_e;

    typedef enum logic [2:0] {VMA = 3'd0, GVMA = 3'd1} iotinval_func_e;
    typedef enum logic [2:0] {INVAL_DDT = 3'd0, INVAL_PDT = 3'd1} iodir_func_e;
    typedef enum logic [2:0] {FENCE_C = 3'd0} iofence_func_e;

    // Common view, only the header is decoded here
    typedef struct packed {
        logic [117:0] payload;
        logic [2:0]   func3;
        logic [6:0]   opcode;
    } cq_entry_t;

    typedef struct packed {
        logic [1:0]  rsvd_5;   // [127:126]
        logic [51:0] addr;     // ADDR[63:12]
        logic [9:0]  rsvd_4;   // [73:64]
        logic [3:0]  rsvd_3;   // [63:60]
        logic [15:0] gscid;
        logic [19:0] pscid;
        logic [9:0]  rsvd_2;   // [23:14]
        logic        gv;
        logic        pscv;
        logic        rsvd_1;
        logic        av;
        logic [2:0]  func3;
        logic [6:0]  opcode;
    } cq_iotinval_t;

    typedef struct packed {
        logic [63:0] rsvd_4;   // Whole second doubleword
        logic [23:0] did;
        logic [5:0]  rsvd_3;
        logic        dv;
        logic        rsvd_2;
        logic [19:0] pid;
        logic [1:0]  rsvd_1;
        logic [2:0]  func3;
        logic [6:0]  opcode;
    } cq_iodir_t;

    typedef struct packed {
        logic [61:0] addr;     // ADDR[63:2]
        logic [1:0]  rsvd_2;
        logic [31:0] data;
        logic [17:0] rsvd_1;
        logic        pw;
        logic        pr;
        logic        wsi;
        logic        av;
        logic [2:0]  func3;
        logic [6:0]  opcode;
    } cq_iofence_t;

    // Cache flush request, valid with flush_valid_o only
    typedef struct packed {
        logic              vma;
        logic              gvma;
        logic              av;
        logic              gv;
        logic              pscv;
        logic [GPPN_W-1:0] vpn;
        logic [15:0]       gscid;
        logic [19:0]       pscid;
        logic              ddtc;
        logic              dv;
        logic [23:0]       did;
        logic              pdtc;
        logic              pv;
        logic [19:0]       pid;
    } flush_req_t;

    typedef struct packed {
        logic                  we;     // 1 = 32-bit write, 0 = 128-bit entry read
        logic [MEM_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [127:0] rdata;
        logic         err;     // Access fault, sticky cq_mf in the handler
    } mem_rsp_t;

endpackage
